// File: hdl/cache_dir_config.svh
// Size settings for the cache tag directory.
// The address holds tag bits above set bits and has no line offset.
// Changing a width requires a full rebuild of every file that includes this header.

`ifndef CACHE_DIR_CONFIG_SVH
`define CACHE_DIR_CONFIG_SVH

// 64 sets
`define CD_SET_BITS 6
// 4 ways
`define CD_WAY_BITS 2
`define CD_TAG_BITS 8

`endif

// File: hdl/cache_dir_pkg.sv
// Types shared by the tag directory blocks.
// Widths come from the config header, so it must be on the include path.

`include "cache_dir_config.svh"

package cache_dir_pkg;

    // Request operation carried with every accepted request
    typedef enum logic {
        OP_LOOKUP = 1'b0,
        OP_INVAL  = 1'b1
    } cd_op_t;

    // Index of one set in the tag and LRU memories
    typedef logic [`CD_SET_BITS-1:0] set_idx_t;

    // Index of one way inside a set
    typedef logic [`CD_WAY_BITS-1:0] way_idx_t;

    // Tag taken from the upper part of the request address
    typedef logic [`CD_TAG_BITS-1:0] tag_t;

endpackage

// File: hdl/lru_if.sv
// Link between the directory controller and the LRU order table.
// Write strobes are single-cycle; init beats up and up beats down.
// victim belongs to the set addressed by raddr one cycle earlier.

`timescale 1ns/1ps

interface lru_if import cache_dir_pkg::*; ();

    set_idx_t raddr;
    set_idx_t waddr;
    logic     init;
    logic     up;
    logic     down;
    way_idx_t lru_way;
    way_idx_t victim;

    modport ctrl (
        output raddr, waddr, init, up, down, lru_way,
        input  victim
    );

    modport tbl (
        input  raddr, waddr, init, up, down, lru_way,
        output victim
    );

endinterface

// File: hdl/lru_table.sv
// Per-set true-LRU order memory with a registered read address.
// The memory has no reset; every set must be written with init before use.
// up and down rework the line that was read, so the write set has to match
// the set read one cycle earlier.

`timescale 1ns/1ps

`include "cache_dir_config.svh"

module lru_table import cache_dir_pkg::*; (
    input logic i_clk,
    lru_if.tbl  lru
);

    localparam int WAYS = 2 ** `CD_WAY_BITS;
    localparam int SETS = 2 ** `CD_SET_BITS;

    // Entry 0 is the least recent way, entry WAYS-1 the most recent one
    way_idx_t [WAYS-1:0] order_mem [SETS];

    set_idx_t            raddr_q;
    way_idx_t [WAYS-1:0] rd_line;
    way_idx_t [WAYS-1:0] init_line;
    way_idx_t [WAYS-1:0] up_line;
    way_idx_t [WAYS-1:0] down_line;
    way_idx_t [WAYS-1:0] wr_line;
    way_idx_t            pos;
    logic                we;

    assign rd_line    = order_mem[raddr_q];
    assign lru.victim = rd_line[0];
    assign we         = lru.init || lru.up || lru.down;

    // Where the selected way sits in the current order
    always_comb begin
        pos = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (rd_line[i] == lru.lru_way) begin
                pos = way_idx_t'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            init_line[i] = way_idx_t'(i);

            // Entries above the old slot drop by one and the way lands on top
            if (i < int'(pos)) begin
                up_line[i] = rd_line[i];
            end else if (i < WAYS - 1) begin
                up_line[i] = rd_line[i + 1];
            end else begin
                up_line[i] = lru.lru_way;
            end

            // Entries below the old slot rise by one and the way lands at the bottom
            if (i > int'(pos)) begin
                down_line[i] = rd_line[i];
            end else if (i > 0) begin
                down_line[i] = rd_line[i - 1];
            end else begin
                down_line[i] = lru.lru_way;
            end
        end
    end

    always_comb begin
        if (lru.init) begin
            wr_line = init_line;
        end else if (lru.up) begin
            wr_line = up_line;
        end else begin
            wr_line = down_line;
        end
    end

    always_ff @(posedge i_clk) begin
        raddr_q <= lru.raddr;
        if (we) begin
            order_mem[lru.waddr] <= wr_line;
        end
    end

endmodule

// File: hdl/tag_store.sv
// Tag and valid storage for every way of every set.
// A whole set is read through a registered address and shows up one cycle later.
// Contents are undefined until i_clr_set has cleared the valid bits of each set.

`timescale 1ns/1ps

`include "cache_dir_config.svh"

module tag_store import cache_dir_pkg::*; (
    input  logic                          i_clk,
    input  set_idx_t                      i_raddr,
    input  logic                          i_we,
    input  set_idx_t                      i_waddr,
    input  way_idx_t                      i_wway,
    input  tag_t                          i_wtag,
    input  logic                          i_wvalid,
    input  logic                          i_clr_set,
    output tag_t [2**`CD_WAY_BITS-1:0]    o_tags,
    output logic [2**`CD_WAY_BITS-1:0]    o_valid
);

    localparam int WAYS = 2 ** `CD_WAY_BITS;
    localparam int SETS = 2 ** `CD_SET_BITS;

    tag_t [WAYS-1:0] tag_mem   [SETS];
    logic [WAYS-1:0] valid_mem [SETS];

    set_idx_t raddr_q;

    always_ff @(posedge i_clk) begin
        raddr_q <= i_raddr;
    end

    // Tags keep their old value on a clear; only the valid bits matter
    always_ff @(posedge i_clk) begin
        if (i_clr_set) begin
            valid_mem[i_waddr] <= '0;
        end else if (i_we) begin
            valid_mem[i_waddr][i_wway] <= i_wvalid;
        end
    end

    // An invalidate rewrites the old tag, which keeps the write port simple
    always_ff @(posedge i_clk) begin
        if (i_we && !i_clr_set) begin
            tag_mem[i_waddr][i_wway] <= i_wtag;
        end
    end

    assign o_tags  = tag_mem[raddr_q];
    assign o_valid = valid_mem[raddr_q];

endmodule

// File: hdl/cache_dir_ctrl.sv
// Directory controller: reset sweep, one request stage, hit detection and updates.
// Requests are ignored until the sweep has initialised every set and o_ready is high.
// Results are valid only in the o_done cycle; there is no back-pressure.
// The set of i_addr goes straight to both read ports, so the stores present
// the set one cycle after the request edge.

`timescale 1ns/1ps

`include "cache_dir_config.svh"

module cache_dir_ctrl import cache_dir_pkg::*; (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_req,
    input  cd_op_t                              i_op,
    input  logic [`CD_TAG_BITS+`CD_SET_BITS-1:0] i_addr,
    output logic                                o_ready,
    output logic                                o_done,
    output logic                                o_hit,
    output way_idx_t                            o_way,
    lru_if.ctrl                                 lru,
    output set_idx_t                            o_ts_raddr,
    output logic                                o_ts_we,
    output set_idx_t                            o_ts_waddr,
    output way_idx_t                            o_ts_wway,
    output tag_t                                o_ts_wtag,
    output logic                                o_ts_wvalid,
    output logic                                o_ts_clr_set,
    input  tag_t [2**`CD_WAY_BITS-1:0]          i_ts_tags,
    input  logic [2**`CD_WAY_BITS-1:0]          i_ts_valid
);

    localparam int WAYS = 2 ** `CD_WAY_BITS;

    logic     ready_q;
    set_idx_t sweep_cnt;
    logic     accept;
    logic     req_q;
    cd_op_t   op_q;
    tag_t     tag_q;
    set_idx_t set_q;
    logic     hit;
    way_idx_t hit_way;
    way_idx_t result_way;
    set_idx_t wr_set;

    assign accept = i_req && ready_q;

    // Sweep one set per cycle after reset, then stay ready
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ready_q   <= 1'b0;
            sweep_cnt <= '0;
            req_q     <= 1'b0;
        end else begin
            if (!ready_q) begin
                sweep_cnt <= sweep_cnt + set_idx_t'(1);
                if (&sweep_cnt) begin
                    ready_q <= 1'b1;
                end
            end
            req_q <= accept;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            op_q  <= i_op;
            tag_q <= i_addr[`CD_TAG_BITS+`CD_SET_BITS-1:`CD_SET_BITS];
            set_q <= i_addr[`CD_SET_BITS-1:0];
        end
    end

    // Tag compare across all ways of the set that was read
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (i_ts_valid[w] && (i_ts_tags[w] == tag_q)) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign result_way = hit ? hit_way : lru.victim;
    assign wr_set     = ready_q ? set_q : sweep_cnt;

    assign o_ready = ready_q;
    assign o_done  = req_q;
    assign o_hit   = hit;
    assign o_way   = result_way;

    assign lru.raddr   = i_addr[`CD_SET_BITS-1:0];
    assign lru.waddr   = wr_set;
    assign lru.init    = !ready_q;
    assign lru.lru_way = result_way;

    assign o_ts_raddr   = i_addr[`CD_SET_BITS-1:0];
    assign o_ts_waddr   = wr_set;
    assign o_ts_wway    = result_way;
    assign o_ts_wtag    = tag_q;
    assign o_ts_clr_set = !ready_q;

    // Update commands for the request resolved in this cycle
    always_comb begin
        lru.up      = 1'b0;
        lru.down    = 1'b0;
        o_ts_we     = 1'b0;
        o_ts_wvalid = 1'b0;
        if (req_q) begin
            case (op_q)
                OP_LOOKUP: begin
                    lru.up = 1'b1;
                    // A miss refills the victim way with the new tag
                    if (!hit) begin
                        o_ts_we     = 1'b1;
                        o_ts_wvalid = 1'b1;
                    end
                end
                OP_INVAL: begin
                    // The freed way sinks to the bottom and is the next victim
                    if (hit) begin
                        o_ts_we  = 1'b1;
                        lru.down = 1'b1;
                    end
                end
                default: begin
                    lru.up = 1'b0;
                end
            endcase
        end
    end

endmodule

// File: hdl/cache_dir_top.sv
// Top level of the cache tag directory with plain ports.
// The address carries the tag in the upper bits and the set in the lower bits.
// o_ready stays low for one sweep of all sets after reset is released.

`timescale 1ns/1ps

`include "cache_dir_config.svh"

module cache_dir_top import cache_dir_pkg::*; (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_req,
    input  cd_op_t                              i_op,
    input  logic [`CD_TAG_BITS+`CD_SET_BITS-1:0] i_addr,
    output logic                                o_ready,
    output logic                                o_done,
    output logic                                o_hit,
    output way_idx_t                            o_way
);

    set_idx_t                       ts_raddr;
    logic                           ts_we;
    set_idx_t                       ts_waddr;
    way_idx_t                       ts_wway;
    tag_t                           ts_wtag;
    logic                           ts_wvalid;
    logic                           ts_clr_set;
    tag_t [2**`CD_WAY_BITS-1:0]     ts_tags;
    logic [2**`CD_WAY_BITS-1:0]     ts_valid;

    lru_if lru_bus ();

    cache_dir_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_req        (i_req),
        .i_op         (i_op),
        .i_addr       (i_addr),
        .o_ready      (o_ready),
        .o_done       (o_done),
        .o_hit        (o_hit),
        .o_way        (o_way),
        .lru          (lru_bus.ctrl),
        .o_ts_raddr   (ts_raddr),
        .o_ts_we      (ts_we),
        .o_ts_waddr   (ts_waddr),
        .o_ts_wway    (ts_wway),
        .o_ts_wtag    (ts_wtag),
        .o_ts_wvalid  (ts_wvalid),
        .o_ts_clr_set (ts_clr_set),
        .i_ts_tags    (ts_tags),
        .i_ts_valid   (ts_valid)
    );

    tag_store u_tags (
        .i_clk     (i_clk),
        .i_raddr   (ts_raddr),
        .i_we      (ts_we),
        .i_waddr   (ts_waddr),
        .i_wway    (ts_wway),
        .i_wtag    (ts_wtag),
        .i_wvalid  (ts_wvalid),
        .i_clr_set (ts_clr_set),
        .o_tags    (ts_tags),
        .o_valid   (ts_valid)
    );

    lru_table u_lru (
        .i_clk (i_clk),
        .lru   (lru_bus.tbl)
    );

endmodule

// File: sim/cache_dir_checker.sv
// Reference model of tags, valid bits and LRU order, plus output comparison.
// All ports are sampled at the rising edge, i.e. the values settled in the cycle before.
// o_way is not compared on an invalidate miss, where it has no meaning.

`timescale 1ns/1ps

`include "cache_dir_config.svh"

module cache_dir_checker import cache_dir_pkg::*; (
    input  logic                                 i_clk,
    input  logic                                 i_rst_n,
    input  logic                                 i_req,
    input  cd_op_t                               i_op,
    input  logic [`CD_TAG_BITS+`CD_SET_BITS-1:0] i_addr,
    input  logic                                 i_exp_chk,
    input  logic                                 i_exp_hit,
    input  way_idx_t                             i_exp_way,
    input  logic                                 i_ready,
    input  logic                                 i_done,
    input  logic                                 i_hit,
    input  way_idx_t                             i_way,
    output int                                   o_errors,
    output int                                   o_checked
);

    localparam int WAYS = 2 ** `CD_WAY_BITS;
    localparam int SETS = 2 ** `CD_SET_BITS;

    // Order index 0 holds the least recently used way
    tag_t     m_tag   [SETS][WAYS];
    logic     m_valid [SETS][WAYS];
    way_idx_t m_order [SETS][WAYS];

    int       err_cnt = 0;
    int       chk_cnt = 0;
    int       rel_cycles;
    logic     pend;
    cd_op_t   p_op;
    tag_t     p_tag;
    set_idx_t p_set;
    logic     p_exp_chk;
    logic     p_exp_hit;
    way_idx_t p_exp_way;
    logic     m_hit;
    way_idx_t m_way;

    assign o_errors  = err_cnt;
    assign o_checked = chk_cnt;

    task automatic report_value(input string name, input logic [7:0] exp, input logic [7:0] act);
        err_cnt++;
        $display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    endtask

    task automatic move_way(input set_idx_t s, input way_idx_t w, input logic to_top);
        int p;
        p = 0;
        for (int i = 0; i < WAYS; i++) begin
            if (m_order[s][i] == w) begin
                p = i;
            end
        end
        if (to_top) begin
            for (int i = p; i < WAYS - 1; i++) begin
                m_order[s][i] = m_order[s][i + 1];
            end
            m_order[s][WAYS - 1] = w;
        end else begin
            for (int i = p; i > 0; i--) begin
                m_order[s][i] = m_order[s][i - 1];
            end
            m_order[s][0] = w;
        end
    endtask

    // A lookup miss takes the bottom way; an invalidate hit frees its way and sinks it
    task automatic resolve(input cd_op_t op, input tag_t tag, input set_idx_t s);
        m_hit = 1'b0;
        m_way = m_order[s][0];
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == tag) begin
                m_hit = 1'b1;
                m_way = way_idx_t'(w);
            end
        end
        if (op == OP_LOOKUP) begin
            m_tag[s][m_way]   = tag;
            m_valid[s][m_way] = 1'b1;
            move_way(s, m_way, 1'b1);
        end else if (m_hit) begin
            m_valid[s][m_way] = 1'b0;
            move_way(s, m_way, 1'b0);
        end
    endtask

    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            rel_cycles = 0;
            pend       = 1'b0;
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    m_valid[s][w] = 1'b0;
                    m_order[s][w] = way_idx_t'(w);
                end
            end
        end else begin
            if (rel_cycles == SETS && i_ready !== 1'b1) begin
                err_cnt++;
                $display("o_ready did not rise within the %0d cycle sweep (%0t)", SETS, $time);
            end else if (i_ready !== (rel_cycles >= SETS)) begin
                report_value("o_ready", rel_cycles >= SETS, i_ready);
            end
            if (pend) begin
                resolve(p_op, p_tag, p_set);
                chk_cnt++;
            end
            if (i_done !== pend) begin
                err_cnt++;
                if (pend) begin
                    $display("Missing o_done for an accepted request at %0t", $time);
                end else begin
                    $display("o_done seen without an accepted request at %0t", $time);
                end
            end else if (pend) begin
                if (i_hit !== m_hit) begin
                    report_value("o_hit", m_hit, i_hit);
                end
                if ((p_op == OP_LOOKUP || m_hit) && i_way !== m_way) begin
                    report_value("o_way", m_way, i_way);
                end
                if (p_exp_chk && i_hit !== p_exp_hit) begin
                    report_value("o_hit (table)", p_exp_hit, i_hit);
                end
                if (p_exp_chk && (p_op == OP_LOOKUP || p_exp_hit) && i_way !== p_exp_way) begin
                    report_value("o_way (table)", p_exp_way, i_way);
                end
            end
            pend      = i_req && (rel_cycles >= SETS);
            p_op      = i_op;
            p_tag     = i_addr[`CD_TAG_BITS+`CD_SET_BITS-1:`CD_SET_BITS];
            p_set     = i_addr[`CD_SET_BITS-1:0];
            p_exp_chk = i_exp_chk;
            p_exp_hit = i_exp_hit;
            p_exp_way = i_exp_way;
            if (rel_cycles <= SETS) begin
                rel_cycles++;
            end
        end
    end

endmodule

// File: sim/tb_cache_dir.sv
// Testbench for the cache tag directory: reset sweep, a directed table, then
// random traffic on two sets. Inputs change on the falling clock edge.

`timescale 1ns/1ps

`include "cache_dir_config.svh"

module tb_cache_dir import cache_dir_pkg::*; ();

    localparam int PERIOD    = 20;
    localparam int SWEEP     = 2 ** `CD_SET_BITS;
    localparam int TABLE_LEN = 20;
    localparam int RAND_REQS = 200;
    localparam int SEED      = 39686;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 req;
    cd_op_t                               op;
    logic [`CD_TAG_BITS+`CD_SET_BITS-1:0] addr;
    logic                                 exp_chk;
    logic                                 exp_hit;
    way_idx_t                             exp_way;
    logic                                 ready;
    logic                                 done;
    logic                                 hit;
    way_idx_t                             way;
    int                                   errors;
    int                                   checked;

    cd_op_t   tbl_op  [TABLE_LEN];
    tag_t     tbl_tag [TABLE_LEN];
    set_idx_t tbl_set [TABLE_LEN];
    logic     tbl_hit [TABLE_LEN];
    way_idx_t tbl_way [TABLE_LEN];
    int       n_steps = 0;

    cache_dir_top dut0 (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_req   (req),
        .i_op    (op),
        .i_addr  (addr),
        .o_ready (ready),
        .o_done  (done),
        .o_hit   (hit),
        .o_way   (way)
    );

    cache_dir_checker chk0 (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_req     (req),
        .i_op      (op),
        .i_addr    (addr),
        .i_exp_chk (exp_chk),
        .i_exp_hit (exp_hit),
        .i_exp_way (exp_way),
        .i_ready   (ready),
        .i_done    (done),
        .i_hit     (hit),
        .i_way     (way),
        .o_errors  (errors),
        .o_checked (checked)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic add_step(input cd_op_t o, input tag_t t, input set_idx_t s, input logic h,
                            input way_idx_t w);
        tbl_op[n_steps]  = o;
        tbl_tag[n_steps] = t;
        tbl_set[n_steps] = s;
        tbl_hit[n_steps] = h;
        tbl_way[n_steps] = w;
        n_steps++;
    endtask

    task automatic issue(input cd_op_t o, input tag_t t, input set_idx_t s, input logic chk,
                         input logic h, input way_idx_t w);
        @(negedge clk);
        req     = 1'b1;
        op      = o;
        addr    = {t, s};
        exp_chk = chk;
        exp_hit = h;
        exp_way = w;
    endtask

    initial begin
        #((SWEEP + TABLE_LEN + RAND_REQS + 20) * PERIOD);
        $display("Watchdog expired before the tests finished");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int rnd;
        clk     = 1'b0;
        rst_n   = 1'b0;
        req     = 1'b0;
        op      = OP_LOOKUP;
        addr    = '0;
        exp_chk = 1'b0;
        exp_hit = 1'b0;
        exp_way = '0;
        void'($urandom(SEED));
        // Four misses fill set 5 in init order, then hits reorder it
        add_step(OP_LOOKUP, 8'h10, 6'd5, 1'b0, 2'd0);
        add_step(OP_LOOKUP, 8'h11, 6'd5, 1'b0, 2'd1);
        add_step(OP_LOOKUP, 8'h12, 6'd5, 1'b0, 2'd2);
        add_step(OP_LOOKUP, 8'h13, 6'd5, 1'b0, 2'd3);
        add_step(OP_LOOKUP, 8'h10, 6'd5, 1'b1, 2'd0);
        add_step(OP_LOOKUP, 8'h12, 6'd5, 1'b1, 2'd2);
        add_step(OP_LOOKUP, 8'h11, 6'd5, 1'b1, 2'd1);
        add_step(OP_LOOKUP, 8'h14, 6'd5, 1'b0, 2'd3);
        add_step(OP_LOOKUP, 8'h13, 6'd5, 1'b0, 2'd0);
        // The invalidated way is reused by the next miss
        add_step(OP_INVAL,  8'h11, 6'd5, 1'b1, 2'd1);
        add_step(OP_LOOKUP, 8'h11, 6'd5, 1'b0, 2'd1);
        add_step(OP_INVAL,  8'h55, 6'd5, 1'b0, 2'd0);
        add_step(OP_LOOKUP, 8'h12, 6'd5, 1'b1, 2'd2);
        add_step(OP_LOOKUP, 8'h10, 6'd6, 1'b0, 2'd0);
        add_step(OP_LOOKUP, 8'h10, 6'd5, 1'b0, 2'd3);
        add_step(OP_INVAL,  8'h10, 6'd5, 1'b1, 2'd3);
        add_step(OP_INVAL,  8'h10, 6'd5, 1'b0, 2'd0);
        add_step(OP_LOOKUP, 8'h10, 6'd6, 1'b1, 2'd0);
        add_step(OP_LOOKUP, 8'h20, 6'd5, 1'b0, 2'd3);
        add_step(OP_LOOKUP, 8'h13, 6'd5, 1'b1, 2'd0);

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // A request during the sweep must not be accepted
        repeat (4) @(negedge clk);
        issue(OP_LOOKUP, 8'h77, 6'd5, 1'b0, 1'b0, 2'd0);
        @(negedge clk);
        req = 1'b0;
        while (ready !== 1'b1) begin
            @(negedge clk);
        end

        for (int i = 0; i < TABLE_LEN; i++) begin
            issue(tbl_op[i], tbl_tag[i], tbl_set[i], 1'b1, tbl_hit[i], tbl_way[i]);
        end
        // Two sets and six tags keep evictions frequent
        for (int i = 0; i < RAND_REQS; i++) begin
            rnd = $urandom;
            issue((rnd[1:0] == 2'b00) ? OP_INVAL : OP_LOOKUP, tag_t'(8'h30 + (rnd[7:4] % 6)),
                  rnd[8] ? set_idx_t'(40) : set_idx_t'(9), 1'b0, 1'b0, 2'd0);
        end
        @(negedge clk);
        req     = 1'b0;
        exp_chk = 1'b0;
        repeat (3) @(negedge clk);

        if (checked != TABLE_LEN + RAND_REQS) begin
            $display("Only %0d of %0d requests were resolved", checked, TABLE_LEN + RAND_REQS);
        end
        $display("Run complete: %0d requests checked, %0d errors", checked, errors);
        if (errors == 0 && checked == TABLE_LEN + RAND_REQS) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+hdl
hdl/cache_dir_pkg.sv
hdl/lru_if.sv
hdl/lru_table.sv
hdl/tag_store.sv
hdl/cache_dir_ctrl.sv
hdl/cache_dir_top.sv
sim/cache_dir_checker.sv
sim/tb_cache_dir.sv
